/* all.f */
source/udp_cmd_pkg.sv
source/byte_fifo.sv
source/cmd_frame_decoder.sv
source/cmd_reg_file.sv
source/key_debounce.sv
source/status_reply_tx.sv
source/udp_cmd_top.sv
sim/udp_cmd_tb.sv

/* sim/udp_cmd_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module udp_cmd_tb;

    localparam logic [7:0] DEV_KIND        = 8'h05;
    localparam int         RX_DEPTH        = 16;
    localparam int         DEBOUNCE_CYCLES = 8;
    localparam int         REPLY_LEN       = udp_cmd_pkg::REPLY_LEN;
    localparam int         NUM_FRAMES      = 40;
    localparam int         STALL_FRAMES    = 8;
    localparam int         MAX_FRAME_LEN   = 10;
    localparam int         KEY_HOLD        = 3 * DEBOUNCE_CYCLES;
    localparam int         NUM_PRESSES     = 5;
    localparam int         CYCLE_LIMIT     = 16 + (NUM_FRAMES + STALL_FRAMES) * MAX_FRAME_LEN * 4
                                             + NUM_PRESSES * (KEY_HOLD + DEBOUNCE_CYCLES + 4)
                                             + 3 * REPLY_LEN * 16 + 500;

    logic                   sys_clk;
    logic                   rst;
    logic                   rx_valid;
    udp_cmd_pkg::udp_beat_t rx_beat;
    logic                   rx_credit;
    logic                   key;
    logic                   tx_credit;
    logic                   tx_valid;
    udp_cmd_pkg::udp_beat_t tx_beat;
    udp_cmd_pkg::reg_bank_t cfg_regs;

    // reference model state
    udp_cmd_pkg::reg_bank_t model_regs = '0;
    logic [7:0]             model_good = 8'd0;
    logic [7:0]             model_bad  = 8'd0;
    logic [7:0]             exp_reply [REPLY_LEN];

    int  cycle_count      = 0;
    int  rx_sent          = 0;
    int  rx_returned      = 0;
    int  tx_granted       = 0;
    int  tx_sent          = 0;
    int  reply_idx        = 0;
    int  replies_done     = 0;
    int  replies_expected = 0;
    logic tx_hold         = 1'b0;

    udp_cmd_top #(
        .DEV_KIND        (DEV_KIND),
        .RX_DEPTH        (RX_DEPTH),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) i_dut (
        .sys_clk   (sys_clk),
        .rst       (rst),
        .rx_valid  (rx_valid),
        .rx_beat   (rx_beat),
        .rx_credit (rx_credit),
        .key       (key),
        .tx_credit (tx_credit),
        .tx_valid  (tx_valid),
        .tx_beat   (tx_beat),
        .cfg_regs  (cfg_regs)
    );

    initial begin
        sys_clk = 1'b0;
        forever #20 sys_clk = ~sys_clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    // counts on both links, reply byte position, run limit
    always @(posedge sys_clk) begin
        cycle_count <= cycle_count + 1;
        if (rx_valid) rx_sent <= rx_sent + 1;
        if (rx_credit) rx_returned <= rx_returned + 1;
        if (tx_credit) tx_granted <= tx_granted + 1;
        if (tx_valid) begin
            tx_sent <= tx_sent + 1;
            if (reply_idx == REPLY_LEN - 1) begin
                reply_idx    <= 0;
                replies_done <= replies_done + 1;
            end else begin
                reply_idx <= reply_idx + 1;
            end
        end
        if (cycle_count >= CYCLE_LIMIT) begin
            report_failure("timeout: the DUT did not finish the test sequence in time");
        end
    end

    // MAC side keeps at most one transmit credit outstanding
    always @(negedge sys_clk) begin
        tx_credit = !rst && !tx_hold && (tx_granted == tx_sent) && ($urandom_range(0, 1) == 1);
    end

    a_rx_credit: assert property (@(posedge sys_clk) disable iff (rst)
        rx_returned + int'(rx_credit) <= rx_sent)
        else report_failure($sformatf("ERROR rx_credit returned %h beats sent %h",
                                      $sampled(rx_returned) + 1, $sampled(rx_sent)));

    a_tx_credit: assert property (@(posedge sys_clk) disable iff (rst)
        tx_sent + int'(tx_valid) <= tx_granted)
        else report_failure($sformatf("ERROR tx_valid count %h credits granted %h",
                                      $sampled(tx_sent) + 1, $sampled(tx_granted)));

    a_tx_expected: assert property (@(posedge sys_clk) disable iff (rst)
        tx_valid |-> replies_done < replies_expected)
        else report_failure($sformatf("ERROR tx_valid replies done %h expected %h",
                                      $sampled(replies_done), $sampled(replies_expected)));

    a_tx_data: assert property (@(posedge sys_clk) disable iff (rst)
        tx_valid |-> tx_beat.data == exp_reply[reply_idx])
        else report_failure($sformatf("ERROR tx_beat.data byte %0d got %h expected %h",
                                      $sampled(reply_idx), $sampled(tx_beat.data),
                                      exp_reply[$sampled(reply_idx)]));

    a_tx_last: assert property (@(posedge sys_clk) disable iff (rst)
        tx_valid |-> tx_beat.last == (reply_idx == REPLY_LEN - 1))
        else report_failure($sformatf("ERROR tx_beat.last byte %0d got %h",
                                      $sampled(reply_idx), $sampled(tx_beat.last)));

    // waits for a receive credit before each beat
    task automatic send_beat(input logic [7:0] data, input logic last);
        while (RX_DEPTH - rx_sent + rx_returned <= 0) begin
            rx_valid = 1'b0;
            @(negedge sys_clk);
        end
        rx_valid     = 1'b1;
        rx_beat.data = data;
        rx_beat.last = last;
        @(negedge sys_clk);
        rx_valid = 1'b0;
    endtask

    // kind 0 good, 1 wrong header, 2 bad index, 3 ends on an index byte
    task automatic send_frame(input int kind);
        logic [7:0] bytes[$];
        logic [2:0] idx;
        logic [7:0] val;
        int         npairs;
        int         bad_at;
        npairs = $urandom_range(1, 4);
        bad_at = $urandom_range(0, npairs - 1);
        bytes.push_back((kind == 1) ? DEV_KIND ^ 8'($urandom_range(1, 255)) : DEV_KIND);
        for (int p = 0; p < npairs; p++) begin
            idx = 3'($urandom_range(0, 7));
            val = 8'($urandom);
            if (kind == 2 && p == bad_at) begin
                bytes.push_back({5'($urandom_range(1, 31)), idx});
            end else begin
                bytes.push_back({5'd0, idx});
            end
            bytes.push_back(val);
            // pairs before the first fault still land
            if (kind == 0 || kind == 3 || (kind == 2 && p < bad_at)) begin
                model_regs[idx] = val;
            end
        end
        if (kind == 3) bytes.push_back({5'd0, 3'($urandom_range(0, 7))});
        if (kind == 0) model_good = model_good + 8'd1;
        else model_bad = model_bad + 8'd1;
        for (int i = 0; i < bytes.size(); i++) begin
            send_beat(bytes[i], i == bytes.size() - 1);
        end
    endtask

    task automatic wait_rx_idle();
        while (rx_returned != rx_sent) @(negedge sys_clk);
        repeat (3) @(negedge sys_clk);
    endtask

    task automatic check_regs();
        assert (cfg_regs == model_regs)
            else report_failure($sformatf("ERROR cfg_regs got %h expected %h",
                                          cfg_regs, model_regs));
    endtask

    task automatic press_key(input int hold, input bit expect_reply);
        if (expect_reply) begin
            exp_reply[0] = DEV_KIND;
            for (int r = 0; r < udp_cmd_pkg::NUM_REGS; r++) exp_reply[r + 1] = model_regs[r];
            exp_reply[9]     = model_good;
            exp_reply[10]    = model_bad;
            replies_expected = replies_expected + 1;
        end
        key = 1'b1;
        repeat (hold) @(negedge sys_clk);
        key = 1'b0;
        repeat (DEBOUNCE_CYCLES + 4) @(negedge sys_clk);
    endtask

    task automatic wait_replies();
        while (replies_done != replies_expected) @(negedge sys_clk);
    endtask

    initial begin
        void'($urandom(32'h0e284a1d));
        rst       = 1'b1;
        rx_valid  = 1'b0;
        rx_beat   = '0;
        key       = 1'b0;
        tx_credit = 1'b0;
        repeat (16) @(negedge sys_clk);
        rst = 1'b0;

        repeat (NUM_FRAMES) send_frame($urandom_range(0, 3));
        wait_rx_idle();
        check_regs();
        press_key(KEY_HOLD, 1'b1);
        wait_replies();

        // glitch shorter than the debounce window
        press_key(DEBOUNCE_CYCLES - 3, 1'b0);
        repeat (40) @(negedge sys_clk);

        // reply stalls while registers move underneath
        tx_hold = 1'b1;
        press_key(KEY_HOLD, 1'b1);
        repeat (STALL_FRAMES) send_frame($urandom_range(0, 3));
        wait_rx_idle();
        check_regs();
        press_key(KEY_HOLD, 1'b0);
        tx_hold = 1'b0;
        wait_replies();
        repeat (40) @(negedge sys_clk);

        press_key(KEY_HOLD, 1'b1);
        wait_replies();
        repeat (10) @(negedge sys_clk);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* source/udp_cmd_top.sv */
`timescale 1ns/10ps
`default_nettype none

module udp_cmd_top #(
    parameter logic [7:0] DEV_KIND        = 8'h05,
    parameter int         RX_DEPTH        = 16,
    parameter int         DEBOUNCE_CYCLES = 50000
) (
    input  wire                    sys_clk,
    input  wire                    rst,
    input  wire                    rx_valid,
    input  udp_cmd_pkg::udp_beat_t rx_beat,
    output logic                   rx_credit,
    input  wire                    key,
    input  wire                    tx_credit,
    output logic                   tx_valid,
    output udp_cmd_pkg::udp_beat_t tx_beat,
    output udp_cmd_pkg::reg_bank_t cfg_regs
);

    logic                       fifo_not_empty;
    udp_cmd_pkg::udp_beat_t     fifo_head;
    logic                       fifo_pop;
    logic                       reg_wr_valid;
    udp_cmd_pkg::reg_write_t    reg_wr;
    udp_cmd_pkg::frame_result_t frame_res;
    udp_cmd_pkg::reg_bank_t     regs;
    logic [7:0]                 good_count;
    logic [7:0]                 bad_count;
    logic                       press;

    assign cfg_regs = regs;

    byte_fifo #(
        .DEPTH(RX_DEPTH)
    ) i_rx_fifo (
        .sys_clk   (sys_clk),
        .rst       (rst),
        .push      (rx_valid),
        .push_beat (rx_beat),
        .pop       (fifo_pop),
        .not_empty (fifo_not_empty),
        .head      (fifo_head),
        .credit    (rx_credit)
    );

    cmd_frame_decoder #(
        .DEV_KIND(DEV_KIND)
    ) i_decoder (
        .sys_clk      (sys_clk),
        .rst          (rst),
        .not_empty    (fifo_not_empty),
        .head         (fifo_head),
        .pop          (fifo_pop),
        .reg_wr_valid (reg_wr_valid),
        .reg_wr       (reg_wr),
        .frame_res    (frame_res)
    );

    cmd_reg_file i_reg_file (
        .sys_clk      (sys_clk),
        .rst          (rst),
        .reg_wr_valid (reg_wr_valid),
        .reg_wr       (reg_wr),
        .frame_res    (frame_res),
        .regs         (regs),
        .good_count   (good_count),
        .bad_count    (bad_count)
    );

    key_debounce #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) i_key (
        .sys_clk (sys_clk),
        .rst     (rst),
        .key     (key),
        .press   (press)
    );

    status_reply_tx #(
        .DEV_KIND(DEV_KIND)
    ) i_reply_tx (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .press      (press),
        .regs       (regs),
        .good_count (good_count),
        .bad_count  (bad_count),
        .tx_credit  (tx_credit),
        .tx_valid   (tx_valid),
        .tx_beat    (tx_beat)
    );

endmodule

`default_nettype wire

/* source/status_reply_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module status_reply_tx #(
    parameter logic [7:0] DEV_KIND = 8'h05
) (
    input  wire                    sys_clk,
    input  wire                    rst,
    input  wire                    press,
    input  udp_cmd_pkg::reg_bank_t regs,
    input  wire [7:0]              good_count,
    input  wire [7:0]              bad_count,
    input  wire                    tx_credit,
    output logic                   tx_valid,
    output udp_cmd_pkg::udp_beat_t tx_beat
);

    localparam int CREDIT_W = 16;
    localparam int IW       = $clog2(udp_cmd_pkg::REPLY_LEN);

    udp_cmd_pkg::reg_bank_t snap_regs;
    logic [7:0]             snap_good;
    logic [7:0]             snap_bad;

    logic                busy;
    logic [IW-1:0]       byte_idx;
    logic [IW-1:0]       reg_off;
    logic [CREDIT_W-1:0] credits;

    assign tx_valid = busy && (credits != '0);
    assign reg_off  = byte_idx - IW'(1);

    // reply byte order: kind, registers 0 to 7, good, bad
    always_comb begin
        tx_beat.last = (byte_idx == IW'(udp_cmd_pkg::REPLY_LEN - 1));
        if (byte_idx == '0) begin
            tx_beat.data = DEV_KIND;
        end else if (byte_idx <= IW'(udp_cmd_pkg::NUM_REGS)) begin
            tx_beat.data = snap_regs[reg_off[2:0]];
        end else if (byte_idx == IW'(udp_cmd_pkg::NUM_REGS + 1)) begin
            tx_beat.data = snap_good;
        end else begin
            tx_beat.data = snap_bad;
        end
    end

    // snapshot is frozen for the whole reply
    always_ff @(posedge sys_clk) begin
        if (press && !busy) begin
            snap_regs <= regs;
            snap_good <= good_count;
            snap_bad  <= bad_count;
        end
    end

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            byte_idx <= '0;
            credits  <= '0;
        end else begin
            credits <= credits + CREDIT_W'(tx_credit) - CREDIT_W'(tx_valid);
            if (!busy) begin
                // presses during a reply are dropped
                busy     <= press;
                byte_idx <= '0;
            end else if (tx_valid) begin
                if (tx_beat.last) begin
                    busy <= 1'b0;
                end
                byte_idx <= byte_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/key_debounce.sv */
`timescale 1ns/10ps
`default_nettype none

module key_debounce #(
    parameter int DEBOUNCE_CYCLES = 50000
) (
    input  wire  sys_clk,
    input  wire  rst,
    input  wire  key,
    output logic press
);

    localparam int CW = $clog2(DEBOUNCE_CYCLES + 1);

    logic [1:0]    sync_q;
    logic [CW-1:0] stable_cnt;
    logic          level;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            sync_q     <= 2'b00;
            stable_cnt <= '0;
            level      <= 1'b0;
            press      <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], key};
            press  <= 1'b0;
            if (sync_q[1] == level) begin
                // any bounce back restarts the wait
                stable_cnt <= '0;
            end else if (stable_cnt == CW'(DEBOUNCE_CYCLES - 1)) begin
                stable_cnt <= '0;
                level      <= sync_q[1];
                press      <= sync_q[1];
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/cmd_reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

module cmd_reg_file (
    input  wire                        sys_clk,
    input  wire                        rst,
    input  wire                        reg_wr_valid,
    input  udp_cmd_pkg::reg_write_t    reg_wr,
    input  udp_cmd_pkg::frame_result_t frame_res,
    output udp_cmd_pkg::reg_bank_t     regs,
    output logic [7:0]                 good_count,
    output logic [7:0]                 bad_count
);

    // register map
    // 0 device kind, 1 filter, 2 and 3 mixer, 4 to 7 spare
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            regs <= '0;
        end else if (reg_wr_valid) begin
            regs[reg_wr.index] <= reg_wr.value;
        end
    end

    // frame statistics, both wrap at 8 bits
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            good_count <= 8'd0;
            bad_count  <= 8'd0;
        end else if (frame_res.done) begin
            if (frame_res.ok) begin
                good_count <= good_count + 8'd1;
            end else begin
                bad_count <= bad_count + 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/cmd_frame_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module cmd_frame_decoder #(
    parameter logic [7:0] DEV_KIND = 8'h05
) (
    input  wire                        sys_clk,
    input  wire                        rst,
    input  wire                        not_empty,
    input  udp_cmd_pkg::udp_beat_t     head,
    output logic                       pop,
    output logic                       reg_wr_valid,
    output udp_cmd_pkg::reg_write_t    reg_wr,
    output udp_cmd_pkg::frame_result_t frame_res
);

    typedef enum logic [1:0] {
        ST_HEADER,
        ST_INDEX,
        ST_VALUE,
        ST_DISCARD
    } state_t;

    state_t     state;
    logic [2:0] idx_q;
    logic       idx_ok;

    // one byte per cycle whenever something is waiting
    assign pop = not_empty;

    // only eight registers, upper index bits must be clear
    assign idx_ok = (head.data[7:3] == 5'd0);

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            state        <= ST_HEADER;
            idx_q        <= '0;
            reg_wr_valid <= 1'b0;
            reg_wr       <= '0;
            frame_res    <= '0;
        end else begin
            reg_wr_valid   <= 1'b0;
            frame_res.done <= 1'b0;
            if (not_empty) begin
                // a completed pair is written right away
                if (state == ST_VALUE) begin
                    reg_wr_valid <= 1'b1;
                    reg_wr.index <= idx_q;
                    reg_wr.value <= head.data;
                end
                if (head.last) begin
                    // good only when last falls on a value byte
                    frame_res.done <= 1'b1;
                    frame_res.ok   <= (state == ST_VALUE);
                    state          <= ST_HEADER;
                end else begin
                    case (state)
                        ST_HEADER: begin
                            state <= (head.data == DEV_KIND) ? ST_INDEX : ST_DISCARD;
                        end
                        ST_INDEX: begin
                            idx_q <= head.data[2:0];
                            state <= idx_ok ? ST_VALUE : ST_DISCARD;
                        end
                        ST_VALUE: begin
                            state <= ST_INDEX;
                        end
                        default: begin
                            state <= ST_DISCARD;
                        end
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/byte_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module byte_fifo #(
    parameter int DEPTH = 16
) (
    input  wire                   sys_clk,
    input  wire                   rst,
    input  wire                   push,
    input  udp_cmd_pkg::udp_beat_t push_beat,
    input  wire                   pop,
    output logic                  not_empty,
    output udp_cmd_pkg::udp_beat_t head,
    output logic                  credit
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    udp_cmd_pkg::udp_beat_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;

    assign not_empty = (count != '0);
    assign head      = mem[rd_ptr];

    always_ff @(posedge sys_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_beat;
        end
    end

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // sender credits keep push from ever hitting a full buffer
            count  <= count + CW'(push) - CW'(pop);
            // one credit back per freed byte
            credit <= pop;
        end
    end

endmodule

`default_nettype wire

/* source/udp_cmd_pkg.sv */
`default_nettype none

package udp_cmd_pkg;

    // command registers held by the board
    localparam int NUM_REGS = 8;

    // kind byte, eight registers, good count, bad count
    localparam int REPLY_LEN = 11;

    // one payload byte with its end-of-frame marker
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } udp_beat_t;

    // single register write from the decoder
    typedef struct packed {
        logic [2:0] index;
        logic [7:0] value;
    } reg_write_t;

    // done pulses once per frame, ok is the verdict
    typedef struct packed {
        logic done;
        logic ok;
    } frame_result_t;

    // element 0 is register 0
    typedef logic [NUM_REGS-1:0][7:0] reg_bank_t;

endpackage

`default_nettype wire
